//--- common/dispatch_pkg.sv
`default_nettype none

package dispatch_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and depths
    ////////////////////////////////////////////////////////////

    localparam int ID_WIDTH   = 2;                   // Micro-ops per rename group
    localparam int SLOT_W     = $clog2(ID_WIDTH);    // Slot index width
    localparam int SEQ_W      = 8;                   // Sequence tag width

    localparam int INT_DEPTH  = 8;
    localparam int INTM_DEPTH = 4;
    localparam int BR_DEPTH   = 4;
    localparam int MEM_DEPTH  = 6;

    // Wide stations take a whole group per cycle
    localparam int WIDE_PORTS = ID_WIDTH;
    localparam int MONO_PORTS = 1;

    localparam int RS_COUNT   = 4;                   // INT, INTM, BR, MEM
    localparam int RS_IDX_W   = $clog2(RS_COUNT);

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    // Target station, value doubles as the issue_select port index
    typedef enum logic [1:0] {
        RS_INT  = 2'd0,
        RS_INTM = 2'd1,
        RS_BR   = 2'd2,
        RS_MEM  = 2'd3
    } rs_type_e;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_MUL = 3'd2,
        OP_DIV = 3'd3,
        OP_BEQ = 3'd4,
        OP_JAL = 3'd5,
        OP_LD  = 3'd6,
        OP_ST  = 3'd7
    } op_e;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [SEQ_W-1:0] seq;       // Carried unchanged to issue
        rs_type_e         rs_type;
        op_e              op;
        logic [4:0]       dest;
        logic [15:0]      imm;
    } uop_t;

    typedef struct packed {
        logic [ID_WIDTH-1:0]       valid;   // One bit per slot
        uop_t [ID_WIDTH-1:0]       uops;
    } group_t;

    // Cycles where a pending op could not enter its station
    typedef struct packed {
        logic [31:0] int_blocked;
        logic [31:0] intm_blocked;
        logic [31:0] br_blocked;
        logic [31:0] mem_blocked;
    } perf_t;

endpackage

`default_nettype wire

//--- logic/group_buffer.sv
`timescale 1ns/100ps
`default_nettype none

// Two-entry input buffer between rename and dispatch
module group_buffer (
    input  logic                 clk,
    input  logic                 rst,

    // From rename
    input  logic                 in_valid,
    output logic                 in_ready,
    input  dispatch_pkg::group_t in_group,

    // To dispatch stage
    output logic                 grp_valid,
    input  logic                 grp_ready,
    output dispatch_pkg::group_t grp
);

    dispatch_pkg::group_t slots [2];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Ready comes from the count register only
    assign in_ready  = (count != 2'd2);
    assign grp_valid = (count != 2'd0);
    assign grp       = slots[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = grp_valid && grp_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);   // Push and pop together keep count
        end
    end

    // Payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= in_group;
        end
    end

endmodule

`default_nettype wire

//--- dispatch/dispatch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_stage (
    input  logic                                          clk,
    input  logic                                          rst,

    // Group from the input buffer
    input  logic                                          grp_valid,
    output logic                                          grp_ready,
    input  dispatch_pkg::group_t                          grp,

    // Wide stations, one port per slot
    output logic                 [dispatch_pkg::ID_WIDTH-1:0] int_enq,
    output logic                 [dispatch_pkg::ID_WIDTH-1:0] intm_enq,
    output dispatch_pkg::uop_t   [dispatch_pkg::ID_WIDTH-1:0] int_uops,
    output dispatch_pkg::uop_t   [dispatch_pkg::ID_WIDTH-1:0] intm_uops,

    // Mono stations, one op per cycle
    output logic                                          br_enq,
    output logic                                          mem_enq,
    output dispatch_pkg::uop_t                            br_uop,
    output dispatch_pkg::uop_t                            mem_uop,

    input  logic                                          int_ready,
    input  logic                                          intm_ready,
    input  logic                                          br_ready,
    input  logic                                          mem_ready,

    output dispatch_pkg::perf_t                           perf
);

    logic [dispatch_pkg::ID_WIDTH-1:0] sent;      // Slots already dispatched
    logic [dispatch_pkg::ID_WIDTH-1:0] pending;
    logic [dispatch_pkg::ID_WIDTH-1:0] int_pend;
    logic [dispatch_pkg::ID_WIDTH-1:0] intm_pend;
    logic [dispatch_pkg::ID_WIDTH-1:0] br_pend;
    logic [dispatch_pkg::ID_WIDTH-1:0] mem_pend;
    logic [dispatch_pkg::ID_WIDTH-1:0] br_go;
    logic [dispatch_pkg::ID_WIDTH-1:0] mem_go;
    logic [dispatch_pkg::ID_WIDTH-1:0] go;
    logic [dispatch_pkg::ID_WIDTH-1:0] done;
    logic [dispatch_pkg::SLOT_W-1:0]   br_sel;
    logic [dispatch_pkg::SLOT_W-1:0]   mem_sel;

    // Lowest set bit of a slot mask
    function automatic logic [dispatch_pkg::SLOT_W-1:0] first_slot(
        input logic [dispatch_pkg::ID_WIDTH-1:0] mask
    );
        logic [dispatch_pkg::SLOT_W-1:0] idx;
        idx = '0;
        for (int i = dispatch_pkg::ID_WIDTH - 1; i >= 0; i--) begin
            if (mask[i]) begin
                idx = dispatch_pkg::SLOT_W'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////
    // Slot decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        int_pend  = '0;
        intm_pend = '0;
        br_pend   = '0;
        mem_pend  = '0;
        for (int i = 0; i < dispatch_pkg::ID_WIDTH; i++) begin
            pending[i] = grp_valid && grp.valid[i] && !sent[i];
            unique case (grp.uops[i].rs_type)
                dispatch_pkg::RS_INT:  int_pend[i]  = pending[i];
                dispatch_pkg::RS_INTM: intm_pend[i] = pending[i];
                dispatch_pkg::RS_BR:   br_pend[i]   = pending[i];
                dispatch_pkg::RS_MEM:  mem_pend[i]  = pending[i];
                default: begin
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Station ports
    ////////////////////////////////////////////////////////////

    // Wide stations take every pending slot at its own index
    assign int_enq   = int_ready  ? int_pend  : '0;
    assign intm_enq  = intm_ready ? intm_pend : '0;
    assign int_uops  = grp.uops;
    assign intm_uops = grp.uops;

    // Mono stations take the oldest pending slot of their type
    assign br_sel  = first_slot(br_pend);
    assign mem_sel = first_slot(mem_pend);
    assign br_enq  = br_ready && (|br_pend);
    assign mem_enq = mem_ready && (|mem_pend);
    assign br_uop  = grp.uops[br_sel];
    assign mem_uop = grp.uops[mem_sel];

    assign br_go  = br_enq  ? (dispatch_pkg::ID_WIDTH'(1) << br_sel)  : '0;
    assign mem_go = mem_enq ? (dispatch_pkg::ID_WIDTH'(1) << mem_sel) : '0;
    assign go     = int_enq | intm_enq | br_go | mem_go;

    // Release once every valid slot is gone
    assign done      = sent | go | ~grp.valid;
    assign grp_ready = grp_valid && (&done);

    always_ff @(posedge clk) begin
        if (rst) begin
            sent <= '0;
        end else if (grp_ready) begin
            sent <= '0;                 // Next group starts clean
        end else if (grp_valid) begin
            sent <= sent | go;
        end
    end

    ////////////////////////////////////////////////////////////
    // Blocked-cycle counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            perf <= '0;
        end else begin
            if ((|int_pend) && !int_ready) begin
                perf.int_blocked <= perf.int_blocked + 32'd1;
            end
            if ((|intm_pend) && !intm_ready) begin
                perf.intm_blocked <= perf.intm_blocked + 32'd1;
            end
            if ((|br_pend) && !br_ready) begin
                perf.br_blocked <= perf.br_blocked + 32'd1;
            end
            if ((|mem_pend) && !mem_ready) begin
                perf.mem_blocked <= perf.mem_blocked + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/rs_queue.sv
`timescale 1ns/100ps
`default_nettype none

// In-order reservation station, PORTS enqueues and one issue per cycle
module rs_queue #(
    parameter int DEPTH = 8,
    parameter int PORTS = 1
) (
    input  logic                                 clk,
    input  logic                                 rst,

    input  logic               [PORTS-1:0]       enq,
    input  dispatch_pkg::uop_t [PORTS-1:0]       enq_uops,
    output logic                                 enq_ready,

    output logic                                 head_valid,
    output dispatch_pkg::uop_t                   head,
    input  logic                                 pop
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dispatch_pkg::uop_t entries [DEPTH];

    logic [PTR_W-1:0] head_ptr;
    logic [PTR_W-1:0] tail_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] n_enq;          // Entries written this cycle
    logic [PTR_W-1:0] wr_idx [PORTS];
    logic [PORTS-1:0] enq_ok;
    logic             do_pop;

    // Pointer advance with wrap, depth need not be a power of two
    function automatic logic [PTR_W-1:0] wrap_add(
        input logic [PTR_W-1:0] base,
        input int               inc
    );
        int sum;
        sum = int'(base) + inc;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    ////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////

    assign enq_ready  = (count <= CNT_W'(DEPTH - PORTS));  // Room for a full set of ports
    assign enq_ok     = enq & {PORTS{enq_ready}};
    assign head_valid = (count != '0);
    assign head       = entries[head_ptr];
    assign do_pop     = pop && head_valid;

    // Set ports fill consecutive entries in port order
    always_comb begin
        n_enq = '0;
        for (int p = 0; p < PORTS; p++) begin
            wr_idx[p] = wrap_add(tail_ptr, int'(n_enq));
            if (enq_ok[p]) begin
                n_enq = n_enq + CNT_W'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // State
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            tail_ptr <= wrap_add(tail_ptr, int'(n_enq));
            if (do_pop) begin
                head_ptr <= wrap_add(head_ptr, 1);
            end
            count <= count + n_enq - CNT_W'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < PORTS; p++) begin
            if (enq_ok[p]) begin
                entries[wr_idx[p]] <= enq_uops[p];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/issue_select.sv
`timescale 1ns/100ps
`default_nettype none

// Round-robin pick of one station head per cycle
module issue_select (
    input  logic                                                clk,
    input  logic                                                rst,

    input  logic               [dispatch_pkg::RS_COUNT-1:0]     head_valid,
    input  dispatch_pkg::uop_t [dispatch_pkg::RS_COUNT-1:0]     heads,
    output logic               [dispatch_pkg::RS_COUNT-1:0]     pop,

    output logic                                                out_valid,
    input  logic                                                out_ready,
    output dispatch_pkg::uop_t                                  out_uop
);

    logic [dispatch_pkg::RS_IDX_W-1:0] last_ptr;   // Station served last
    logic [dispatch_pkg::RS_IDX_W-1:0] sel;
    logic                              xfer;

    // Search starts just after the last served station
    always_comb begin
        logic found;
        int   idx;
        found = 1'b0;
        sel   = last_ptr;
        for (int k = 1; k <= dispatch_pkg::RS_COUNT; k++) begin
            idx = (int'(last_ptr) + k) % dispatch_pkg::RS_COUNT;
            if (!found && head_valid[idx]) begin
                sel   = dispatch_pkg::RS_IDX_W'(idx);
                found = 1'b1;
            end
        end
    end

    assign out_valid = |head_valid;
    assign out_uop   = heads[sel];
    assign xfer      = out_valid && out_ready;

    always_comb begin
        pop = '0;
        if (xfer) begin
            pop[sel] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Fairness pointer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            last_ptr <= dispatch_pkg::RS_IDX_W'(dispatch_pkg::RS_COUNT - 1);  // INT goes first
        end else if (xfer) begin
            last_ptr <= sel;
        end
    end

endmodule

`default_nettype wire

//--- logic/dispatch_core.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_core (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 in_valid,
    output logic                 in_ready,
    input  dispatch_pkg::group_t in_group,

    output logic                 out_valid,
    input  logic                 out_ready,
    output dispatch_pkg::uop_t   out_uop,

    output dispatch_pkg::perf_t  perf
);

    logic                 grp_valid;
    logic                 grp_ready;
    dispatch_pkg::group_t grp;

    logic               [dispatch_pkg::ID_WIDTH-1:0] int_enq;
    logic               [dispatch_pkg::ID_WIDTH-1:0] intm_enq;
    dispatch_pkg::uop_t [dispatch_pkg::ID_WIDTH-1:0] int_uops;
    dispatch_pkg::uop_t [dispatch_pkg::ID_WIDTH-1:0] intm_uops;
    logic                                            br_enq;
    logic                                            mem_enq;
    dispatch_pkg::uop_t                              br_uop;
    dispatch_pkg::uop_t                              mem_uop;
    logic                                            int_ready;
    logic                                            intm_ready;
    logic                                            br_ready;
    logic                                            mem_ready;

    // Station side, indexed by rs_type_e value
    logic               [dispatch_pkg::RS_COUNT-1:0] head_valid;
    dispatch_pkg::uop_t [dispatch_pkg::RS_COUNT-1:0] heads;
    logic               [dispatch_pkg::RS_COUNT-1:0] pop;

    group_buffer buf0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_group  (in_group),
        .grp_valid (grp_valid),
        .grp_ready (grp_ready),
        .grp       (grp)
    );

    dispatch_stage ds0 (
        .clk        (clk),
        .rst        (rst),
        .grp_valid  (grp_valid),
        .grp_ready  (grp_ready),
        .grp        (grp),
        .int_enq    (int_enq),
        .intm_enq   (intm_enq),
        .int_uops   (int_uops),
        .intm_uops  (intm_uops),
        .br_enq     (br_enq),
        .mem_enq    (mem_enq),
        .br_uop     (br_uop),
        .mem_uop    (mem_uop),
        .int_ready  (int_ready),
        .intm_ready (intm_ready),
        .br_ready   (br_ready),
        .mem_ready  (mem_ready),
        .perf       (perf)
    );

    ////////////////////////////////////////////////////////////
    // Reservation stations
    ////////////////////////////////////////////////////////////

    rs_queue #(.DEPTH(dispatch_pkg::INT_DEPTH), .PORTS(dispatch_pkg::WIDE_PORTS)) int_rs (
        .clk(clk), .rst(rst),
        .enq(int_enq), .enq_uops(int_uops), .enq_ready(int_ready),
        .head_valid(head_valid[0]), .head(heads[0]), .pop(pop[0])
    );

    rs_queue #(.DEPTH(dispatch_pkg::INTM_DEPTH), .PORTS(dispatch_pkg::WIDE_PORTS)) intm_rs (
        .clk(clk), .rst(rst),
        .enq(intm_enq), .enq_uops(intm_uops), .enq_ready(intm_ready),
        .head_valid(head_valid[1]), .head(heads[1]), .pop(pop[1])
    );

    rs_queue #(.DEPTH(dispatch_pkg::BR_DEPTH), .PORTS(dispatch_pkg::MONO_PORTS)) br_rs (
        .clk(clk), .rst(rst),
        .enq(br_enq), .enq_uops(br_uop), .enq_ready(br_ready),
        .head_valid(head_valid[2]), .head(heads[2]), .pop(pop[2])
    );

    rs_queue #(.DEPTH(dispatch_pkg::MEM_DEPTH), .PORTS(dispatch_pkg::MONO_PORTS)) mem_rs (
        .clk(clk), .rst(rst),
        .enq(mem_enq), .enq_uops(mem_uop), .enq_ready(mem_ready),
        .head_valid(head_valid[3]), .head(heads[3]), .pop(pop[3])
    );

    issue_select sel0 (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .heads      (heads),
        .pop        (pop),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_uop    (out_uop)
    );

endmodule

`default_nettype wire

//--- verif/dispatch_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_core_tb;

    localparam int          MAX_GROUPS = 64;
    localparam logic [1:0]  PH_FREE    = 2'd0;
    localparam logic [1:0]  PH_STALL   = 2'd1;
    localparam logic [1:0]  PH_HOLD    = 2'd2;
    localparam logic [1:0]  PH_IDLE    = 2'd3;
    localparam logic [31:0] SEED       = 32'h57448493;

    logic                 clk;
    logic                 rst;
    logic                 in_valid;
    logic                 in_ready;
    dispatch_pkg::group_t in_group;
    logic                 out_valid;
    logic                 out_ready;
    dispatch_pkg::uop_t   out_uop;
    dispatch_pkg::perf_t  perf;

    dispatch_pkg::group_t tr_group [MAX_GROUPS];
    logic [1:0]           tr_phase [MAX_GROUPS];
    int                   n_groups;

    // Expected ops per station with the oldest at the front
    dispatch_pkg::uop_t sb_int [$];
    dispatch_pkg::uop_t sb_intm [$];
    dispatch_pkg::uop_t sb_br [$];
    dispatch_pkg::uop_t sb_mem [$];

    logic [1:0]                     cur_phase;
    logic [1:0]                     phase_q;        // Phase as seen at the rising edge
    logic                           hold_release;
    logic                           in_ready_fell;
    int                             low_cycles;
    logic [31:0]                    rand_state;
    logic [dispatch_pkg::SEQ_W-1:0] next_seq;
    string                          test_name;
    int                             errors;
    int                             err_base;
    int                             checks;
    int                             tests_run;
    int                             tests_failed;
    int                             ops_sent;
    int                             ops_issued;
    int                             cycles;
    int                             cycle_limit;

    dispatch_core dut0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_group  (in_group),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_uop   (out_uop),
        .perf      (perf)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic string uop_str(input dispatch_pkg::uop_t u);
        return $sformatf("{seq=%02h type=%0d op=%0d dest=%02h imm=%04h}",
                         u.seq, u.rs_type, u.op, u.dest, u.imm);
    endfunction

    function automatic string perf_str(input dispatch_pkg::perf_t p);
        return $sformatf("{int=%0d intm=%0d br=%0d mem=%0d}",
                         p.int_blocked, p.intm_blocked, p.br_blocked, p.mem_blocked);
    endfunction

    function automatic dispatch_pkg::uop_t make_uop(input logic [31:0] t, input logic [31:0] o,
                                                    input logic [31:0] d, input logic [31:0] m);
        dispatch_pkg::uop_t u;
        u.seq     = '0;
        u.rs_type = dispatch_pkg::rs_type_e'(t[1:0]);
        u.op      = dispatch_pkg::op_e'(o[2:0]);
        u.dest    = d[4:0];
        u.imm     = m[15:0];
        return u;
    endfunction

    ////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_bit(input string name, input string sig, input logic exp,
                             input logic act);
        checks++;
        if (act !== exp) begin
            $display("MISMATCH %s %s expected %b actual %b", name, sig, exp, act);
            errors++;
        end
    endtask

    task automatic check_uop(input string name, input dispatch_pkg::uop_t exp,
                             input dispatch_pkg::uop_t act);
        checks++;
        if (act.seq !== exp.seq || act.rs_type !== exp.rs_type || act.op !== exp.op ||
            act.dest !== exp.dest || act.imm !== exp.imm) begin
            $display("MISMATCH %s expected %s actual %s", name, uop_str(exp), uop_str(act));
            errors++;
        end
    endtask

    task automatic check_perf(input string name, input dispatch_pkg::perf_t exp,
                              input dispatch_pkg::perf_t act);
        checks++;
        if (act !== exp) begin
            $display("MISMATCH %s expected %s actual %s", name, perf_str(exp), perf_str(act));
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Trace and stimulus
    ////////////////////////////////////////////////////////////

    task automatic load_trace(output logic ok);
        int                   fd;
        int                   n;
        logic [8*128-1:0]     line;
        logic [8*8-1:0]       tag;
        logic [31:0]          mask;
        logic [31:0]          t0;
        logic [31:0]          o0;
        logic [31:0]          d0;
        logic [31:0]          m0;
        logic [31:0]          t1;
        logic [31:0]          o1;
        logic [31:0]          d1;
        logic [31:0]          m1;
        dispatch_pkg::group_t grp;
        fd       = $fopen("verif/dispatch_trace.txt", "r");
        ok       = (fd != 0);
        n_groups = 0;
        if (ok) begin
            while (!$feof(fd) && n_groups < MAX_GROUPS) begin
                line = '0;
                n    = $fgets(line, fd);
                n    = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h",
                               tag, mask, t0, o0, d0, m0, t1, o1, d1, m1);
                if (n == 10) begin                  // Comment lines stop early
                    grp         = '0;
                    grp.valid   = mask[dispatch_pkg::ID_WIDTH-1:0];
                    grp.uops[0] = make_uop(t0, o0, d0, m0);
                    grp.uops[1] = make_uop(t1, o1, d1, m1);
                    tr_group[n_groups] = grp;
                    if (tag == "hold") begin
                        tr_phase[n_groups] = PH_HOLD;
                    end else if (tag == "stall") begin
                        tr_phase[n_groups] = PH_STALL;
                    end else begin
                        tr_phase[n_groups] = PH_FREE;
                    end
                    n_groups++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_groups * dispatch_pkg::ID_WIDTH * 8 + 200;
    endtask

    task automatic push_group(input dispatch_pkg::group_t grp);
        for (int i = 0; i < dispatch_pkg::ID_WIDTH; i++) begin
            if (grp.valid[i]) begin
                ops_sent++;
                case (grp.uops[i].rs_type)
                    dispatch_pkg::RS_INT:  sb_int.push_back(grp.uops[i]);
                    dispatch_pkg::RS_INTM: sb_intm.push_back(grp.uops[i]);
                    dispatch_pkg::RS_BR:   sb_br.push_back(grp.uops[i]);
                    default:               sb_mem.push_back(grp.uops[i]);
                endcase
            end
        end
    endtask

    // Holds the group from a falling edge until it is taken
    task automatic send_group(input int g);
        dispatch_pkg::group_t grp;
        logic                 accepted;
        grp = tr_group[g];
        for (int i = 0; i < dispatch_pkg::ID_WIDTH; i++) begin
            if (grp.valid[i]) begin
                grp.uops[i].seq = next_seq;
                next_seq++;
            end
        end
        in_group = grp;
        in_valid = 1'b1;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = in_ready;
            if (accepted) begin
                push_group(grp);
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    function automatic int pending_ops();
        return sb_int.size() + sb_intm.size() + sb_br.size() + sb_mem.size();
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        err_base  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_base) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - err_base);
        end
    endtask

    task automatic finish_phase(input logic [1:0] ph);
        dispatch_pkg::perf_t others;
        if (ph == PH_HOLD && !in_ready_fell) begin
            $display("in_ready never fell while the hold phase offered groups");
            errors++;
        end
        while (pending_ops() != 0) begin
            @(negedge clk);
        end
        // Hold runs first, so only INT may have counted by now
        if (ph == PH_HOLD) begin
            checks++;
            if (perf.int_blocked == 32'd0) begin
                $display("MISMATCH %s int_blocked expected nonzero actual %0d",
                         test_name, perf.int_blocked);
                errors++;
            end
            others             = perf;
            others.int_blocked = '0;
            check_perf(test_name, '0, others);
        end
        end_test();
    endtask

    task automatic run_tests();
        logic [1:0] ph;
        begin_test("reset");
        repeat (4) begin
            @(negedge clk);
            check_bit(test_name, "out_valid", 1'b0, out_valid);
            check_bit(test_name, "in_ready", 1'b1, in_ready);
        end
        rst = 1'b0;
        @(negedge clk);
        check_bit(test_name, "out_valid", 1'b0, out_valid);
        check_bit(test_name, "in_ready", 1'b1, in_ready);
        check_perf(test_name, '0, perf);
        end_test();

        ph = PH_IDLE;
        for (int g = 0; g < n_groups; g++) begin
            if (tr_phase[g] != ph) begin
                if (ph != PH_IDLE) begin
                    finish_phase(ph);
                end
                ph            = tr_phase[g];
                cur_phase     = ph;
                in_ready_fell = 1'b0;
                begin_test(ph == PH_HOLD ? "phase_hold" :
                           (ph == PH_STALL ? "phase_stall" : "phase_free"));
            end
            send_group(g);
        end
        if (ph != PH_IDLE) begin
            finish_phase(ph);
        end

        begin_test("drain");
        repeat (4) @(negedge clk);
        if (ops_issued != ops_sent) begin
            $display("MISMATCH %s expected %0d ops actual %0d ops",
                     test_name, ops_sent, ops_issued);
            errors++;
        end
        check_bit(test_name, "out_valid", 1'b0, out_valid);
        end_test();
    endtask

    ////////////////////////////////////////////////////////////
    // Issue port and back-pressure
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        rand_state = lcg_next(rand_state);
        case (phase_q)
            PH_FREE:  out_ready = 1'b1;
            PH_STALL: out_ready = (rand_state[31:24] < 8'd77);   // About 30 %
            PH_HOLD:  out_ready = hold_release;
            default:  out_ready = 1'b0;
        endcase
    end

    always @(posedge clk) begin : monitor
        dispatch_pkg::uop_t exp;
        logic               hit;
        if (cur_phase != phase_q) begin
            low_cycles   = 0;
            hold_release = 1'b0;
        end
        phase_q = cur_phase;
        // Release the issue port a few cycles after in_ready drops
        if (!rst && in_valid && !in_ready) begin
            in_ready_fell = 1'b1;
            low_cycles++;
            if (low_cycles >= 4) begin
                hold_release = 1'b1;
            end
        end
        if (!rst && out_valid && out_ready) begin
            ops_issued++;
            hit = 1'b0;
            case (out_uop.rs_type)
                dispatch_pkg::RS_INT: if (sb_int.size() > 0) begin
                    exp = sb_int.pop_front();
                    hit = 1'b1;
                end
                dispatch_pkg::RS_INTM: if (sb_intm.size() > 0) begin
                    exp = sb_intm.pop_front();
                    hit = 1'b1;
                end
                dispatch_pkg::RS_BR: if (sb_br.size() > 0) begin
                    exp = sb_br.pop_front();
                    hit = 1'b1;
                end
                default: if (sb_mem.size() > 0) begin
                    exp = sb_mem.pop_front();
                    hit = 1'b1;
                end
            endcase
            if (hit) begin
                check_uop(test_name, exp, out_uop);
            end else begin
                $display("issue port delivered %s with no op pending for its station",
                         uop_str(out_uop));
                errors++;
            end
        end
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles with %0d ops still pending", cycles, pending_ops());
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin : main
        logic ok;
        clk           = 1'b0;
        rst           = 1'b1;
        in_valid      = 1'b0;
        in_group      = '0;
        out_ready     = 1'b0;
        cur_phase     = PH_IDLE;
        phase_q       = PH_IDLE;
        hold_release  = 1'b0;
        in_ready_fell = 1'b0;
        low_cycles    = 0;
        rand_state    = SEED;
        next_seq      = '0;
        test_name     = "reset";
        errors        = 0;
        err_base      = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        ops_sent      = 0;
        ops_issued    = 0;
        cycles        = 0;
        cycle_limit   = 1000;
        load_trace(ok);
        if (!ok) begin
            $display("cannot open verif/dispatch_trace.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            run_tests();
            $display("tests %0d, failed %0d, checks %0d, errors %0d, ops sent %0d, issued %0d",
                     tests_run, tests_failed, checks, errors, ops_sent, ops_issued);
            if (errors == 0) begin
                $display("*** TEST PASSED ***");
            end else begin
                $display("*** TEST FAILED ***");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dispatch_core.f
common/dispatch_pkg.sv
logic/group_buffer.sv
dispatch/dispatch_stage.sv
logic/rs_queue.sv
logic/issue_select.sv
logic/dispatch_core.sv
verif/dispatch_core_tb.sv

//--- verif/dispatch_trace.txt
# phase mask | slot0 type op dest imm | slot1 type op dest imm (hex)
# type 0 INT 1 INTM 2 BR 3 MEM, op 0 ADD 1 SUB 2 MUL 3 DIV 4 BEQ 5 JAL 6 LD 7 ST
hold 3 0 0 01 1000 0 1 02 1001
hold 3 0 1 03 1002 0 0 04 1003
hold 3 0 0 05 1004 0 0 06 1005
hold 3 0 1 07 1006 0 1 08 1007
hold 3 0 0 09 1008 0 1 0a 1009
hold 3 0 0 0b 100a 0 0 0c 100b
hold 3 0 1 0d 100c 0 0 0e 100d
hold 3 0 0 0f 100e 0 1 10 100f
free 3 0 0 11 2000 1 2 12 2001
free 3 2 4 00 2002 2 5 01 2003
free 3 3 6 13 2004 3 7 00 2005
free 1 3 6 14 2006 0 0 00 0000
free 2 0 0 00 0000 2 4 00 2007
free 3 2 5 02 2008 3 6 15 2009
free 3 1 3 16 200a 1 2 17 200b
free 3 3 7 00 200c 0 1 18 200d
free 3 2 4 00 200e 2 4 00 200f
free 3 0 0 19 2010 2 5 03 2011
stall 3 3 6 1a 3000 3 6 1b 3001
stall 3 3 7 00 3002 3 7 00 3003
stall 3 2 4 00 3004 2 5 04 3005
stall 3 3 6 1c 3006 2 4 00 3007
stall 3 1 2 1d 3008 1 3 1e 3009
stall 3 1 3 1f 300a 0 0 01 300b
stall 3 2 5 05 300c 2 4 00 300d
stall 1 0 1 02 300e 0 0 00 0000
stall 3 3 6 03 3010 3 7 00 3011
stall 3 0 0 04 3012 3 6 05 3013
